//--- common/draw_geom_pkg.sv
package draw_geom_pkg;

  // ----------------------------------------------------------------------
  // screen and border
  // ----------------------------------------------------------------------
  localparam int SCREEN_W = 1280;
  localparam int SCREEN_H = 800;
  localparam int HUD_SIDE = 32;   // left and right strips
  localparam int HUD_TOP  = 96;
  localparam int HUD_BOT  = 0;

  // ----------------------------------------------------------------------
  // tiles and map
  // ----------------------------------------------------------------------
  localparam int BLK_W      = 64;  // power of two
  localparam int BLK_H      = 64;  // power of two
  localparam int BLK_W_LOG2 = $clog2(BLK_W);
  localparam int BLK_H_LOG2 = $clog2(BLK_H);
  localparam int NUM_COL    = 19;
  localparam int NUM_ROW    = 11;
  localparam int MAP_DEPTH  = NUM_COL * NUM_ROW;
  localparam int MAP_ADDR_W = $clog2(MAP_DEPTH);

  localparam int SPRITE_W = 32;  // player box
  localparam int SPRITE_H = 48;

  typedef logic [10:0]           xcoord_t;
  typedef logic [9:0]            ycoord_t;
  typedef logic [MAP_ADDR_W-1:0] map_addr_t;  // row * NUM_COL + col

  typedef struct packed {
    xcoord_t x;
    ycoord_t y;
  } draw_pos_t;

  // map window bounds, lower inclusive and upper exclusive
  localparam xcoord_t   MAP_X_LO   = xcoord_t'(HUD_SIDE);
  localparam xcoord_t   MAP_X_HI   = xcoord_t'(SCREEN_W - HUD_SIDE);
  localparam ycoord_t   MAP_Y_LO   = ycoord_t'(HUD_TOP);
  localparam ycoord_t   MAP_Y_HI   = ycoord_t'(SCREEN_H - HUD_BOT);
  localparam map_addr_t ROW_STRIDE = map_addr_t'(NUM_COL);  // one row down

endpackage

//--- common/tile_pkg.sv
package tile_pkg;

  // what the map memory stores per tile
  typedef enum logic [1:0] {
    NO_BLK,
    PERM_BLK,
    DESTROYABLE_BLK,
    BOMB
  } tile_state_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // ----------------------------------------------------------------------
  // flat palette
  // ----------------------------------------------------------------------
  localparam rgb_t HUD_RGB        = 12'h000;
  localparam rgb_t BG_RGB         = 12'h173;
  localparam rgb_t PERM_RGB       = 12'h888;
  localparam rgb_t DEST_RGB       = 12'hA52;
  localparam rgb_t DEBRIS_RGB     = 12'hF80;  // destroyable tile caught in a blast
  localparam rgb_t BOMB_RGB       = 12'h111;
  localparam rgb_t EXPL_RGB       = 12'hFF0;
  localparam rgb_t ITEM_SPEED_RGB = 12'h0EF;
  localparam rgb_t ITEM_BOMB_RGB  = 12'hE0E;
  localparam rgb_t ITEM_RANGE_RGB = 12'hF00;
  localparam rgb_t P1_RGB         = 12'hFFF;
  localparam rgb_t P2_RGB         = 12'h00F;

  localparam int NUM_BLASTS = 2;
  localparam int NUM_ITEMS  = 3;
  localparam int ITEM_SPEED = 0;  // item order, also the priority
  localparam int ITEM_BOMB  = 1;
  localparam int ITEM_RANGE = 2;

  typedef struct packed {
    logic                     active;
    draw_geom_pkg::map_addr_t centre;
  } blast_t;

  typedef struct packed {
    logic                     active;
    draw_geom_pkg::map_addr_t addr;
  } item_t;

  typedef struct packed {
    logic                 blast_hit;
    logic [NUM_ITEMS-1:0] item_hit;
  } effect_t;

endpackage

//--- design/map_locator.sv
module map_locator (
  input  draw_geom_pkg::draw_pos_t i_draw,
  output logic                     o_in_map,
  output draw_geom_pkg::map_addr_t o_addr
);

  draw_geom_pkg::xcoord_t   map_x;  // position relative to the map corner
  draw_geom_pkg::ycoord_t   map_y;
  draw_geom_pkg::map_addr_t col;
  draw_geom_pkg::map_addr_t row;
  draw_geom_pkg::map_addr_t addr_raw;
  logic                     x_ok;
  logic                     y_ok;

  // ----------------------------------------------------------------------
  // border test
  // ----------------------------------------------------------------------
  assign x_ok = (i_draw.x >= draw_geom_pkg::MAP_X_LO) &&
                (i_draw.x <  draw_geom_pkg::MAP_X_HI);
  assign y_ok = (i_draw.y >= draw_geom_pkg::MAP_Y_LO) &&
                (i_draw.y <  draw_geom_pkg::MAP_Y_HI);

  assign o_in_map = x_ok && y_ok;

  // ----------------------------------------------------------------------
  // tile address
  // ----------------------------------------------------------------------
  // wraps in the border, the result is dropped there anyway
  assign map_x = i_draw.x - draw_geom_pkg::MAP_X_LO;
  assign map_y = i_draw.y - draw_geom_pkg::MAP_Y_LO;

  always_comb begin
    // tiles are a power of two wide, so a shift gives the column
    col      = draw_geom_pkg::map_addr_t'(map_x >> draw_geom_pkg::BLK_W_LOG2);
    row      = draw_geom_pkg::map_addr_t'(map_y >> draw_geom_pkg::BLK_H_LOG2);
    addr_raw = row * draw_geom_pkg::ROW_STRIDE + col;  // at most 208 inside the map
  end

  // the map memory sees address 0 over the border
  assign o_addr = o_in_map ? addr_raw : '0;

endmodule

//--- design/tile_effects.sv
module tile_effects (
  input  draw_geom_pkg::map_addr_t i_addr,
  input  tile_pkg::blast_t         i_blast [tile_pkg::NUM_BLASTS],
  input  tile_pkg::item_t          i_item  [tile_pkg::NUM_ITEMS],
  output tile_pkg::effect_t        o_effect
);

  // centre tile plus its four neighbours
  // left/right is plain +-1, so the ends of a row reach into the next row
  function automatic logic in_cross(input draw_geom_pkg::map_addr_t addr,
                                    input draw_geom_pkg::map_addr_t centre);
    return (addr == centre) ||
           (addr == centre + 1'b1) ||
           (addr == centre - 1'b1) ||
           (addr == centre + draw_geom_pkg::ROW_STRIDE) ||
           (addr == centre - draw_geom_pkg::ROW_STRIDE);
  endfunction

  // ----------------------------------------------------------------------
  // blast and item hits
  // ----------------------------------------------------------------------
  always_comb begin
    o_effect = '0;

    for (int b = 0; b < tile_pkg::NUM_BLASTS; b++) begin
      if (i_blast[b].active && in_cross(i_addr, i_blast[b].centre)) begin
        o_effect.blast_hit = 1'b1;
      end
    end

    // one bit per item, the mixer sorts out the priority
    for (int k = 0; k < tile_pkg::NUM_ITEMS; k++) begin
      o_effect.item_hit[k] = i_item[k].active && (i_item[k].addr == i_addr);
    end
  end

endmodule

//--- design/pixel_mixer.sv
module pixel_mixer (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_in_map,
  input  tile_pkg::tile_state_t     i_tile_state,
  input  tile_pkg::effect_t         i_effect,
  input  draw_geom_pkg::draw_pos_t  i_draw,
  input  draw_geom_pkg::draw_pos_t  i_player_1,
  input  draw_geom_pkg::draw_pos_t  i_player_2,
  output tile_pkg::rgb_t            o_rgb
);

  logic                     in_map_q;
  tile_pkg::tile_state_t    tile_q;
  tile_pkg::effect_t        effect_q;
  draw_geom_pkg::draw_pos_t draw_q;
  draw_geom_pkg::draw_pos_t p1_q;
  draw_geom_pkg::draw_pos_t p2_q;
  logic                     p1_hit;
  logic                     p2_hit;

  // ----------------------------------------------------------------------
  // pipeline stage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      in_map_q <= 1'b0;  // shows the HUD colour until a map pixel arrives
    end else begin
      in_map_q <= i_in_map;
    end
  end

  always_ff @(posedge clk) begin
    tile_q   <= i_tile_state;
    effect_q <= i_effect;
    draw_q   <= i_draw;
    p1_q     <= i_player_1;
    p2_q     <= i_player_2;
  end

  // box test, one bit wider so the far edge never wraps
  function automatic logic in_sprite(input draw_geom_pkg::draw_pos_t pos,
                                     input draw_geom_pkg::draw_pos_t corner);
    logic [11:0] x_end;
    logic [10:0] y_end;
    x_end = {1'b0, corner.x} + 12'(draw_geom_pkg::SPRITE_W);
    y_end = {1'b0, corner.y} + 11'(draw_geom_pkg::SPRITE_H);
    return (pos.x >= corner.x) && ({1'b0, pos.x} < x_end) &&
           (pos.y >= corner.y) && ({1'b0, pos.y} < y_end);
  endfunction

  assign p1_hit = in_sprite(draw_q, p1_q);
  assign p2_hit = in_sprite(draw_q, p2_q);

  // ----------------------------------------------------------------------
  // colour priority
  // ----------------------------------------------------------------------
  always_comb begin
    if (!in_map_q) begin
      o_rgb = tile_pkg::HUD_RGB;
    end else if (p1_hit) begin
      o_rgb = tile_pkg::P1_RGB;  // player 1 drawn on top
    end else if (p2_hit) begin
      o_rgb = tile_pkg::P2_RGB;
    end else begin
      case (tile_q)
        tile_pkg::NO_BLK: begin
          if (effect_q.blast_hit) begin
            o_rgb = tile_pkg::EXPL_RGB;  // fire covers items
          end else if (effect_q.item_hit[tile_pkg::ITEM_SPEED]) begin
            o_rgb = tile_pkg::ITEM_SPEED_RGB;
          end else if (effect_q.item_hit[tile_pkg::ITEM_BOMB]) begin
            o_rgb = tile_pkg::ITEM_BOMB_RGB;
          end else if (effect_q.item_hit[tile_pkg::ITEM_RANGE]) begin
            o_rgb = tile_pkg::ITEM_RANGE_RGB;
          end else begin
            o_rgb = tile_pkg::BG_RGB;
          end
        end
        tile_pkg::PERM_BLK: o_rgb = tile_pkg::PERM_RGB;
        tile_pkg::DESTROYABLE_BLK: begin
          o_rgb = effect_q.blast_hit ? tile_pkg::DEBRIS_RGB : tile_pkg::DEST_RGB;
        end
        default: o_rgb = tile_pkg::BOMB_RGB;  // BOMB
      endcase
    end
  end

endmodule

//--- design/drawcon_top.sv
module drawcon_top (
  input  logic                     clk,
  input  logic                     i_rst,
  input  draw_geom_pkg::draw_pos_t i_draw,
  input  tile_pkg::tile_state_t    i_tile_state,  // from map memory, same cycle
  input  draw_geom_pkg::draw_pos_t i_player_1,
  input  draw_geom_pkg::draw_pos_t i_player_2,
  input  tile_pkg::blast_t         i_blast [tile_pkg::NUM_BLASTS],
  input  tile_pkg::item_t          i_item  [tile_pkg::NUM_ITEMS],
  output draw_geom_pkg::map_addr_t o_map_addr,
  output tile_pkg::rgb_t           o_rgb
);

  logic              in_map;
  tile_pkg::effect_t effect;

  // ----------------------------------------------------------------------
  // same-cycle locate and effect lookup, then one register stage
  // ----------------------------------------------------------------------
  map_locator u_map_locator (
    .i_draw   (i_draw),
    .o_in_map (in_map),
    .o_addr   (o_map_addr)  // also feeds the effect lookup
  );

  tile_effects u_tile_effects (
    .i_addr   (o_map_addr),
    .i_blast  (i_blast),
    .i_item   (i_item),
    .o_effect (effect)
  );

  pixel_mixer u_pixel_mixer (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_in_map     (in_map),
    .i_tile_state (i_tile_state),
    .i_effect     (effect),
    .i_draw       (i_draw),
    .i_player_1   (i_player_1),
    .i_player_2   (i_player_2),
    .o_rgb        (o_rgb)
  );

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 2;  // 4 ns clock

  initial clk = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- testbench/drawcon_properties.sv
module drawcon_properties (
  input logic                     clk,
  input logic                     i_rst,
  input draw_geom_pkg::draw_pos_t i_draw,
  input draw_geom_pkg::map_addr_t o_map_addr,
  input tile_pkg::rgb_t           o_rgb
);
  timeunit 1ns;
  timeprecision 100ps;

  logic outside;

  // border strips worked out from the screen and border sizes
  assign outside = (int'(i_draw.x) < draw_geom_pkg::HUD_SIDE) ||
                   (int'(i_draw.x) >= draw_geom_pkg::SCREEN_W - draw_geom_pkg::HUD_SIDE) ||
                   (int'(i_draw.y) < draw_geom_pkg::HUD_TOP) ||
                   (int'(i_draw.y) >= draw_geom_pkg::SCREEN_H - draw_geom_pkg::HUD_BOT);

  // ----------------------------------------------------------------------
  // port rules
  // ----------------------------------------------------------------------
  addr_zero_outside: assert property (@(posedge clk) outside |-> o_map_addr == '0)
    else $error("map address %0d driven for a border position", o_map_addr);

  hud_after_outside: assert property (@(posedge clk) outside |=> o_rgb == tile_pkg::HUD_RGB)
    else $error("colour after a border position is not the HUD colour");

  hud_after_reset: assert property (@(posedge clk) i_rst |=> o_rgb == tile_pkg::HUD_RGB)
    else $error("colour after a reset cycle is not the HUD colour");

endmodule

bind drawcon_top drawcon_properties u_properties (
  .clk        (clk),
  .i_rst      (i_rst),
  .i_draw     (i_draw),
  .o_map_addr (o_map_addr),
  .o_rgb      (o_rgb)
);

//--- testbench/drawcon_tb.sv
module drawcon_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_FILLER   = 3;
  localparam int SEED         = 32'h1aba2f21;

  typedef struct {
    string                                       name;
    draw_geom_pkg::draw_pos_t                    draw;
    tile_pkg::tile_state_t                       tile;
    draw_geom_pkg::draw_pos_t                    p1;
    draw_geom_pkg::draw_pos_t                    p2;
    tile_pkg::blast_t [tile_pkg::NUM_BLASTS-1:0] blast;
    tile_pkg::item_t  [tile_pkg::NUM_ITEMS-1:0]  item;
    draw_geom_pkg::map_addr_t                    exp_addr;
    tile_pkg::rgb_t                              exp_rgb;
  } row_t;

  logic                     clk;
  logic                     rst;
  draw_geom_pkg::draw_pos_t draw;
  tile_pkg::tile_state_t    tile_state;
  draw_geom_pkg::draw_pos_t player_1;
  draw_geom_pkg::draw_pos_t player_2;
  tile_pkg::blast_t         blast [tile_pkg::NUM_BLASTS];
  tile_pkg::item_t          item  [tile_pkg::NUM_ITEMS];
  draw_geom_pkg::map_addr_t o_map_addr;
  tile_pkg::rgb_t           o_rgb;

  row_t vectors[$];
  int   cycle_count = 0;
  int   cycle_limit = RESET_CYCLES + 20;  // raised once the table is built

  // effects and players shared by the rows added next
  tile_pkg::blast_t [tile_pkg::NUM_BLASTS-1:0] cur_blast;
  tile_pkg::item_t  [tile_pkg::NUM_ITEMS-1:0]  cur_item;
  draw_geom_pkg::draw_pos_t                    cur_p1;
  draw_geom_pkg::draw_pos_t                    cur_p2;

  tb_clock u_clock (.clk(clk));

  drawcon_top uut (
    .clk          (clk),
    .i_rst        (rst),
    .i_draw       (draw),
    .i_tile_state (tile_state),
    .i_player_1   (player_1),
    .i_player_2   (player_2),
    .i_blast      (blast),
    .i_item       (item),
    .o_map_addr   (o_map_addr),
    .o_rgb        (o_rgb)
  );

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic draw_geom_pkg::draw_pos_t xy(input int x, input int y);
    draw_geom_pkg::draw_pos_t p;
    p.x = draw_geom_pkg::xcoord_t'(x);
    p.y = draw_geom_pkg::ycoord_t'(y);
    return p;
  endfunction

  // pixel (dx, dy) inside a tile counted from the map corner
  function automatic draw_geom_pkg::draw_pos_t in_tile(input int addr, input int dx,
                                                       input int dy);
    int x;
    int y;
    x = draw_geom_pkg::HUD_SIDE + (addr % draw_geom_pkg::NUM_COL) * draw_geom_pkg::BLK_W;
    y = draw_geom_pkg::HUD_TOP + (addr / draw_geom_pkg::NUM_COL) * draw_geom_pkg::BLK_H;
    return xy(x + dx, y + dy);
  endfunction

  function automatic tile_pkg::blast_t blast_at(input logic active, input int centre);
    tile_pkg::blast_t b;
    b.active = active;
    b.centre = draw_geom_pkg::map_addr_t'(centre);
    return b;
  endfunction

  function automatic tile_pkg::item_t item_at(input logic active, input int addr);
    tile_pkg::item_t it;
    it.active = active;
    it.addr   = draw_geom_pkg::map_addr_t'(addr);
    return it;
  endfunction

  task automatic add_row(input string name, input draw_geom_pkg::draw_pos_t pos,
                         input tile_pkg::tile_state_t tile, input int exp_addr,
                         input tile_pkg::rgb_t exp_rgb);
    row_t r;
    r.name     = name;
    r.draw     = pos;
    r.tile     = tile;
    r.p1       = cur_p1;
    r.p2       = cur_p2;
    r.blast    = cur_blast;
    r.item     = cur_item;
    r.exp_addr = draw_geom_pkg::map_addr_t'(exp_addr);
    r.exp_rgb  = exp_rgb;
    vectors.push_back(r);
  endtask

  task automatic build_vectors();
    int addr;
    cur_blast = '0;
    cur_item  = '0;
    cur_p1    = xy(0, 0);  // parked in the top HUD and never over the map
    cur_p2    = xy(0, 0);
    add_row("reset_exit", in_tile(5, 10, 10), tile_pkg::PERM_BLK, 5, tile_pkg::PERM_RGB);
    add_row("hud_top", xy(640, 50), tile_pkg::PERM_BLK, 0, tile_pkg::HUD_RGB);
    add_row("hud_left", xy(31, 400), tile_pkg::BOMB, 0, tile_pkg::HUD_RGB);
    add_row("hud_right", xy(1248, 200), tile_pkg::NO_BLK, 0, tile_pkg::HUD_RGB);
    add_row("tile0_first", xy(32, 96), tile_pkg::NO_BLK, 0, tile_pkg::BG_RGB);
    add_row("tile0_last", xy(95, 159), tile_pkg::PERM_BLK, 0, tile_pkg::PERM_RGB);
    add_row("tile20_first", xy(96, 160), tile_pkg::DESTROYABLE_BLK, 20, tile_pkg::DEST_RGB);
    add_row("tile208_last", xy(1247, 799), tile_pkg::BOMB, 208, tile_pkg::BOMB_RGB);

    cur_blast[0] = blast_at(1'b1, 40);
    cur_blast[1] = blast_at(1'b0, 43);  // would reach 42 if active
    add_row("blast_centre", in_tile(40, 0, 0), tile_pkg::NO_BLK, 40, tile_pkg::EXPL_RGB);
    add_row("blast_left", in_tile(39, 63, 63), tile_pkg::NO_BLK, 39, tile_pkg::EXPL_RGB);
    add_row("blast_right", in_tile(41, 5, 30), tile_pkg::DESTROYABLE_BLK, 41,
            tile_pkg::DEBRIS_RGB);
    add_row("blast_up", in_tile(21, 32, 0), tile_pkg::DESTROYABLE_BLK, 21, tile_pkg::DEBRIS_RGB);
    add_row("blast_down", in_tile(59, 0, 63), tile_pkg::NO_BLK, 59, tile_pkg::EXPL_RGB);
    add_row("blast_miss", in_tile(42, 20, 20), tile_pkg::DESTROYABLE_BLK, 42, tile_pkg::DEST_RGB);
    cur_blast[1] = blast_at(1'b1, 43);
    add_row("blast_second", in_tile(42, 50, 10), tile_pkg::DESTROYABLE_BLK, 42,
            tile_pkg::DEBRIS_RGB);

    // items with a blast cross at 100 kept clear of them
    cur_blast[0] = blast_at(1'b1, 100);
    cur_blast[1] = blast_at(1'b0, 0);
    cur_item[tile_pkg::ITEM_SPEED] = item_at(1'b1, 60);
    cur_item[tile_pkg::ITEM_BOMB]  = item_at(1'b1, 60);
    cur_item[tile_pkg::ITEM_RANGE] = item_at(1'b1, 61);
    add_row("item_speed_first", in_tile(60, 7, 7), tile_pkg::NO_BLK, 60, tile_pkg::ITEM_SPEED_RGB);
    add_row("item_range", in_tile(61, 40, 9), tile_pkg::NO_BLK, 61, tile_pkg::ITEM_RANGE_RGB);
    cur_item[tile_pkg::ITEM_SPEED] = item_at(1'b0, 62);
    cur_item[tile_pkg::ITEM_BOMB]  = item_at(1'b1, 62);
    cur_item[tile_pkg::ITEM_RANGE] = item_at(1'b1, 62);
    add_row("item_bomb_first", in_tile(62, 1, 50), tile_pkg::NO_BLK, 62, tile_pkg::ITEM_BOMB_RGB);
    cur_item[tile_pkg::ITEM_SPEED] = item_at(1'b1, 100);
    add_row("item_under_blast", in_tile(100, 3, 3), tile_pkg::NO_BLK, 100, tile_pkg::EXPL_RGB);

    cur_blast = '0;
    cur_item  = '0;
    cur_p1    = xy(200, 300);
    cur_p2    = xy(220, 320);  // overlaps player 1
    add_row("p1_over_perm", xy(200, 300), tile_pkg::PERM_BLK, 59, tile_pkg::P1_RGB);
    add_row("p1_over_p2", xy(225, 330), tile_pkg::NO_BLK, 60, tile_pkg::P1_RGB);
    add_row("p2_only", xy(240, 340), tile_pkg::BOMB, 60, tile_pkg::P2_RGB);
    add_row("p1_past_x", xy(232, 300), tile_pkg::DESTROYABLE_BLK, 60, tile_pkg::DEST_RGB);
    add_row("p1_past_y", xy(200, 348), tile_pkg::PERM_BLK, 59, tile_pkg::PERM_RGB);

    // random empty tiles without effects
    cur_p1 = xy(0, 0);
    cur_p2 = xy(0, 0);
    for (int f = 0; f < NUM_FILLER; f++) begin
      addr = ($urandom % draw_geom_pkg::NUM_ROW) * draw_geom_pkg::NUM_COL +
             ($urandom % draw_geom_pkg::NUM_COL);
      add_row("filler", in_tile(addr, $urandom % draw_geom_pkg::BLK_W,
              $urandom % draw_geom_pkg::BLK_H), tile_pkg::NO_BLK, addr, tile_pkg::BG_RGB);
    end
  endtask

  task automatic apply_row(input row_t r);
    draw       = r.draw;
    tile_state = r.tile;
    player_1   = r.p1;
    player_2   = r.p2;
    for (int b = 0; b < tile_pkg::NUM_BLASTS; b++) begin
      blast[b] = r.blast[b];
    end
    for (int k = 0; k < tile_pkg::NUM_ITEMS; k++) begin
      item[k] = r.item[k];
    end
  endtask

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_addr(input string name, input draw_geom_pkg::map_addr_t exp,
                            input draw_geom_pkg::map_addr_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: o_map_addr expected %0d, actual %0d", name, exp, act);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_rgb(input string name, input tile_pkg::rgb_t exp,
                           input tile_pkg::rgb_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: o_rgb expected %h, actual %h", name, exp, act);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run went past %0d clock cycles", cycle_limit);
      $display("Errors found");
      $fatal(1);
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst        = 1'b1;
    draw       = in_tile(5, 10, 10);  // in the map but hidden during reset
    tile_state = tile_pkg::PERM_BLK;
    player_1   = xy(0, 0);
    player_2   = xy(0, 0);
    for (int b = 0; b < tile_pkg::NUM_BLASTS; b++) begin
      blast[b] = '0;
    end
    for (int k = 0; k < tile_pkg::NUM_ITEMS; k++) begin
      item[k] = '0;
    end

    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_rgb("reset", tile_pkg::HUD_RGB, o_rgb);
    end
    rst = 1'b0;

    void'($urandom(SEED));
    build_vectors();
    cycle_limit = vectors.size() + RESET_CYCLES + 20;

    foreach (vectors[i]) begin
      apply_row(vectors[i]);
      #1;
      check_addr(vectors[i].name, vectors[i].exp_addr, o_map_addr);
      @(posedge clk);
      #1;  // colour of the row registered at this edge
      check_rgb(vectors[i].name, vectors[i].exp_rgb, o_rgb);
    end

    $display("No errors");
    $finish;
  end

endmodule

//--- project.f
common/draw_geom_pkg.sv
common/tile_pkg.sv
design/map_locator.sv
design/tile_effects.sv
design/pixel_mixer.sv
design/drawcon_top.sv
testbench/tb_clock.sv
testbench/drawcon_properties.sv
testbench/drawcon_tb.sv

//--- Makefile
TOP := drawcon_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o sim_drawcon
	./obj_dir/sim_drawcon > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
	  echo "simulation failed"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
